/* hdl/nora_pkg.sv */
// ------------------------------------------------------------
// System controller shared definitions
// ------------------------------------------------------------
package nora_pkg;

    // Bus widths
    localparam int CPU_AW = 16;                 // 65C816 address, bank byte not decoded
    localparam int MEM_AW = 21;                 // 2 MB SRAM
    localparam int DW     = 8;

    // CPU clock phases, six clk6x cycles per CPU cycle
    localparam logic [2:0] PHASES_PER_CYCLE = 3'd6;
    localparam logic [2:0] PH_SETUP_CS      = 3'd2;     // Address valid, start decode
    localparam logic [2:0] PH_PHI2_RISE     = 3'd3;     // First phase of phi2 high
    localparam logic [2:0] PH_RELEASE_WR    = 3'd4;     // Write hold before cs release
    localparam logic [2:0] PH_RELEASE_CS    = 3'd5;     // Last phase of the CPU cycle

    // Memory map
    localparam logic [CPU_AW-1:0] BANK_REG_ADDR = 16'h0000;
    localparam logic [CPU_AW-1:0] VIA_BASE      = 16'h9F00;   // 16 bytes decoded
    localparam logic [CPU_AW-1:0] BANK_WIN_BASE = 16'hA000;   // 8 KB window
    localparam int                BANK_OFS_W    = 13;
    localparam logic [DW-1:0]     RAMBANK_MASK  = 8'h7F;      // 128 banks max

    // Direct memory sits at the top of SRAM, clear of banks 0..127
    localparam logic [MEM_AW-CPU_AW-1:0] LOWMEM_PAGE = 5'h1F;

    // VIA register offsets
    localparam logic [3:0] VIA_ORB  = 4'h0;
    localparam logic [3:0] VIA_ORA  = 4'h1;
    localparam logic [3:0] VIA_DDRB = 4'h2;
    localparam logic [3:0] VIA_DDRA = 4'h3;

    // CPU side of the bus, sampled at setup
    typedef struct packed {
        logic [CPU_AW-1:0] addr;
        logic              rwn;     // 1 = read
        logic [DW-1:0]     wdata;
    } cpu_bus_t;

    // SRAM pins, strobes active low
    typedef struct packed {
        logic [MEM_AW-1:0] addr;
        logic [DW-1:0]     wdata;
        logic              csn;
        logic              rdn;
        logic              wrn;
    } mem_bus_t;

    // Internal slave request
    typedef struct packed {
        logic [3:0]    ofs;         // Register offset within the block
        logic [DW-1:0] wdata;
        logic          we;          // Single clk6x pulse
    } slv_req_t;

    // Bus timing pulses from the phaser
    typedef struct packed {
        logic setup_cs;
        logic release_wr;
        logic release_cs;
    } bus_evt_t;

endpackage

/* hdl/cpu_phaser.sv */
// ------------------------------------------------------------
// CPU clock phaser with run/stop
// ------------------------------------------------------------
`timescale 1ns/1ps

module cpu_phaser
    import nora_pkg::*;
(
    input  logic     clk6x,
    input  logic     rst_i,
    input  logic     run_i,         // Low requests a stop at the next cycle boundary
    output logic     cphi2_o,       // CPU clock, clk6x / 6
    output logic     stopped_o,     // CPU held with phi2 low
    output bus_evt_t evt_o
);

    logic [2:0] phase_q;
    logic [2:0] phase_nxt;
    logic       stop_nxt;

    // Next phase and stop state
    always_comb
    begin
        phase_nxt = phase_q;
        stop_nxt  = stopped_o;
        if (stopped_o)
        begin
            if (run_i)
                stop_nxt = 1'b0;        // Leave stop, phase 0 held one more clock
        end
        else if (phase_q == PHASES_PER_CYCLE - 3'd1)
        begin
            phase_nxt = 3'd0;           // Cycle boundary
            stop_nxt  = !run_i;
        end
        else
        begin
            phase_nxt = phase_q + 3'd1;
        end
    end

    // Outputs registered from the next phase so they line up with phase_q
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            phase_q   <= 3'd0;
            stopped_o <= 1'b0;
            cphi2_o   <= 1'b0;
            evt_o     <= '0;
        end
        else
        begin
            phase_q          <= phase_nxt;
            stopped_o        <= stop_nxt;
            cphi2_o          <= (phase_nxt >= PH_PHI2_RISE);    // High in phases 3..5
            evt_o.setup_cs   <= (phase_nxt == PH_SETUP_CS);
            evt_o.release_wr <= (phase_nxt == PH_RELEASE_WR);
            evt_o.release_cs <= (phase_nxt == PH_RELEASE_CS);
        end
    end

    // A stopped CPU must not see a phi2 edge
    a_no_phi2_when_stopped: assert property (
        @(posedge clk6x) disable iff (rst_i) $rose(cphi2_o) |-> !stopped_o
    ) else $error("cphi2 rose while stopped");

endmodule

/* hdl/bus_decoder.sv */
// ------------------------------------------------------------
// Memory bus controller and address decoder
// ------------------------------------------------------------
`timescale 1ns/1ps

module bus_decoder
    import nora_pkg::*;
(
    input  logic          clk6x,
    input  logic          rst_i,
    input  bus_evt_t      evt_i,
    input  cpu_bus_t      cpu_bus_i,
    input  logic [DW-1:0] mem_rdata_i,
    input  logic [DW-1:0] via_rdata_i,
    output mem_bus_t      mem_o,
    output logic [DW-1:0] cpu_rdata_o,
    output logic          cpu_rdata_oe_o,   // CPU data bus drive enable
    output slv_req_t      slv_o,
    output logic          via_sel_o
);

    typedef enum logic [1:0] {
        ACC_SRAM,       // Direct SRAM below and above the I/O
        ACC_WIN,        // Banked window
        ACC_BANK,       // Bank register
        ACC_VIA         // GPIO slave
    } acc_e;

    acc_e              acc_nxt;
    acc_e              acc_q;
    logic [CPU_AW-1:0] addr_q;
    logic              rwn_q;
    bus_evt_t          evt_d;           // Events delayed one clock
    logic              setup_d2;
    logic [DW-1:0]     bank_q;
    logic              csn_q;
    logic              rdn_q;
    logic              wrn_q;
    logic [DW-1:0]     slv_wdata_q;
    logic              slv_we_q;
    logic              sram_acc;
    logic [MEM_AW-1:0] mem_addr;

    // Memory map decode of the live CPU address
    always_comb
    begin
        if (cpu_bus_i.addr == BANK_REG_ADDR)
            acc_nxt = ACC_BANK;
        else if (cpu_bus_i.addr[CPU_AW-1:4] == VIA_BASE[CPU_AW-1:4])
            acc_nxt = ACC_VIA;
        else if (cpu_bus_i.addr[CPU_AW-1:BANK_OFS_W] == BANK_WIN_BASE[CPU_AW-1:BANK_OFS_W])
            acc_nxt = ACC_WIN;
        else
            acc_nxt = ACC_SRAM;
    end

    // Address, direction and class latched at setup
    always_ff @(posedge clk6x)
    begin
        if (evt_i.setup_cs)
        begin
            addr_q <= cpu_bus_i.addr;
            rwn_q  <= cpu_bus_i.rwn;
            acc_q  <= acc_nxt;
        end
        if (evt_d.release_wr)
            slv_wdata_q <= cpu_bus_i.wdata;     // CPU data final late in phi2
    end

    assign sram_acc = (acc_q == ACC_SRAM) || (acc_q == ACC_WIN);

    // Strobe sequencing
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            evt_d          <= '0;
            setup_d2       <= 1'b0;
            csn_q          <= 1'b1;
            rdn_q          <= 1'b1;
            wrn_q          <= 1'b1;
            cpu_rdata_oe_o <= 1'b0;
            via_sel_o      <= 1'b0;
            slv_we_q       <= 1'b0;
            bank_q         <= '0;
        end
        else
        begin
            evt_d    <= evt_i;
            setup_d2 <= evt_d.setup_cs;
            slv_we_q <= 1'b0;
            if (evt_d.setup_cs)                 // N+1
            begin
                csn_q          <= !sram_acc;    // Internal targets keep SRAM off
                rdn_q          <= !(sram_acc && rwn_q);
                cpu_rdata_oe_o <= rwn_q;
                via_sel_o      <= (acc_q == ACC_VIA);
            end
            if (setup_d2 && sram_acc && !rwn_q)
                wrn_q <= 1'b0;                  // N+2
            if (evt_d.release_wr)               // N+3
            begin
                wrn_q          <= 1'b1;
                cpu_rdata_oe_o <= 1'b0;
                if (!rwn_q && acc_q == ACC_BANK)
                    bank_q <= cpu_bus_i.wdata & RAMBANK_MASK;
                slv_we_q <= !rwn_q && (acc_q == ACC_VIA);
            end
            if (evt_d.release_cs)               // N+4
            begin
                csn_q     <= 1'b1;
                rdn_q     <= 1'b1;
                via_sel_o <= 1'b0;
            end
        end
    end

    // Window maps bank:offset, everything else to the top page
    assign mem_addr = (acc_q == ACC_WIN) ? {bank_q, addr_q[BANK_OFS_W-1:0]}
                                         : {LOWMEM_PAGE, addr_q};

    assign mem_o = '{addr: mem_addr, wdata: cpu_bus_i.wdata,
                     csn: csn_q, rdn: rdn_q, wrn: wrn_q};

    assign slv_o = '{ofs: addr_q[3:0], wdata: slv_wdata_q, we: slv_we_q};

    // Read data source
    always_comb
    begin
        case (acc_q)
            ACC_BANK: cpu_rdata_o = bank_q;
            ACC_VIA:  cpu_rdata_o = via_rdata_i;
            default:  cpu_rdata_o = mem_rdata_i;
        endcase
    end

    // Write pulse ends with csn still low on the following clock
    a_wrn_inside_cs: assert property (
        @(posedge clk6x) disable iff (rst_i) !wrn_q |-> !csn_q ##1 !csn_q
    ) else $error("wrn low outside csn");

    a_bank_masked: assert property (
        @(posedge clk6x) disable iff (rst_i) bank_q <= RAMBANK_MASK
    ) else $error("bank register above mask");

endmodule

/* hdl/gpio_via.sv */
// ------------------------------------------------------------
// Simplified 65C22 GPIO ports
// ------------------------------------------------------------
`timescale 1ns/1ps

module gpio_via
    import nora_pkg::*;
(
    input  logic          clk6x,
    input  logic          rst_i,
    input  slv_req_t      slv_i,
    input  logic          sel_i,        // Block selected for this CPU cycle
    input  logic [DW-1:0] porta_i,
    input  logic [DW-1:0] portb_i,
    output logic [DW-1:0] rdata_o,
    output logic [DW-1:0] porta_o,
    output logic [DW-1:0] porta_oe_o,   // 1 = pin driven
    output logic [DW-1:0] portb_o,
    output logic [DW-1:0] portb_oe_o
);

    logic [DW-1:0] ora_q;
    logic [DW-1:0] orb_q;
    logic [DW-1:0] ddra_q;              // 0 = input, 1 = output
    logic [DW-1:0] ddrb_q;

    // Output bits from the register, input bits from the pin
    function automatic logic [DW-1:0] port_mix(
        input logic [DW-1:0] out_r,
        input logic [DW-1:0] dir,
        input logic [DW-1:0] pin
    );
        return (out_r & dir) | (pin & ~dir);
    endfunction

    // Register writes
    always_ff @(posedge clk6x)
    begin
        if (rst_i)
        begin
            ora_q  <= '0;
            orb_q  <= '0;
            ddra_q <= '0;               // All pins inputs after reset
            ddrb_q <= '0;
        end
        else if (sel_i && slv_i.we)
        begin
            case (slv_i.ofs)
                VIA_ORB:  orb_q  <= slv_i.wdata;
                VIA_ORA:  ora_q  <= slv_i.wdata;
                VIA_DDRB: ddrb_q <= slv_i.wdata;
                VIA_DDRA: ddra_q <= slv_i.wdata;
                default: ;              // Timers and the rest not present
            endcase
        end
    end

    // Read-back, valid while selected
    always_comb
    begin
        case (slv_i.ofs)
            VIA_ORB:  rdata_o = port_mix(orb_q, ddrb_q, portb_i);
            VIA_ORA:  rdata_o = port_mix(ora_q, ddra_q, porta_i);
            VIA_DDRB: rdata_o = ddrb_q;
            VIA_DDRA: rdata_o = ddra_q;
            default:  rdata_o = '0;
        endcase
    end

    // Pin drivers
    assign porta_o    = ora_q;
    assign porta_oe_o = ddra_q;
    assign portb_o    = orb_q;
    assign portb_oe_o = ddrb_q;

    // Strobe from the decoder must fall inside its select window
    a_we_only_selected: assert property (
        @(posedge clk6x) disable iff (rst_i) slv_i.we |-> sel_i
    ) else $error("VIA write strobe without select");

endmodule

/* hdl/nora_top.sv */
// ------------------------------------------------------------
// System controller bus core
// ------------------------------------------------------------
`timescale 1ns/1ps

module nora_top
    import nora_pkg::*;
(
    input  logic          clk6x,
    input  logic          rst_i,
    input  logic          run_i,
    input  cpu_bus_t      cpu_bus_i,
    input  logic [DW-1:0] mem_rdata_i,
    input  logic [DW-1:0] porta_i,
    input  logic [DW-1:0] portb_i,
    output logic          cphi2_o,
    output logic          stopped_o,
    output logic [DW-1:0] cpu_rdata_o,
    output logic          cpu_rdata_oe_o,
    output mem_bus_t      mem_o,
    output logic [DW-1:0] porta_o,
    output logic [DW-1:0] porta_oe_o,
    output logic [DW-1:0] portb_o,
    output logic [DW-1:0] portb_oe_o
);

    bus_evt_t      evt;             // Phase pulses
    slv_req_t      slv_req;         // Decoder to GPIO
    logic          via_sel;
    logic [DW-1:0] via_rdata;

    cpu_phaser phaser_i (
        .clk6x     (clk6x),
        .rst_i     (rst_i),
        .run_i     (run_i),
        .cphi2_o   (cphi2_o),
        .stopped_o (stopped_o),
        .evt_o     (evt)
    );

    bus_decoder decoder_i (
        .clk6x          (clk6x),
        .rst_i          (rst_i),
        .evt_i          (evt),
        .cpu_bus_i      (cpu_bus_i),
        .mem_rdata_i    (mem_rdata_i),
        .via_rdata_i    (via_rdata),
        .mem_o          (mem_o),
        .cpu_rdata_o    (cpu_rdata_o),
        .cpu_rdata_oe_o (cpu_rdata_oe_o),
        .slv_o          (slv_req),
        .via_sel_o      (via_sel)
    );

    gpio_via via_i (
        .clk6x      (clk6x),
        .rst_i      (rst_i),
        .slv_i      (slv_req),
        .sel_i      (via_sel),
        .porta_i    (porta_i),
        .portb_i    (portb_i),
        .rdata_o    (via_rdata),
        .porta_o    (porta_o),
        .porta_oe_o (porta_oe_o),
        .portb_o    (portb_o),
        .portb_oe_o (portb_oe_o)
    );

endmodule

/* dv/tb_nora.sv */
// ------------------------------------------------------------
// Bus core directed testbench
// ------------------------------------------------------------
`timescale 1ns/1ps

module tb_nora
    import nora_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRV_DLY      = 2;            // Input skew after the rising edge
    localparam int RST_CYCLES   = 3;
    localparam int CYCLE_CLKS   = 6;            // clk6x per CPU cycle
    localparam int N_TESTS      = 5;
    localparam int ACC_PER_TEST = 24;           // Upper bound on CPU cycles per test
    localparam int WATCHDOG_NS  = N_TESTS * ACC_PER_TEST * CYCLE_CLKS * CLK_PERIOD * 4;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic          clk6x = 1'b0;
    logic          rst_i;
    logic          run_i;
    cpu_bus_t      cpu_bus_i;
    logic [DW-1:0] mem_rdata_i = '0;
    logic [DW-1:0] porta_i;
    logic [DW-1:0] portb_i;
    logic          cphi2_o;
    logic          stopped_o;
    logic [DW-1:0] cpu_rdata_o;
    logic          cpu_rdata_oe_o;
    mem_bus_t      mem_o;
    logic [DW-1:0] porta_o;
    logic [DW-1:0] porta_oe_o;
    logic [DW-1:0] portb_o;
    logic [DW-1:0] portb_oe_o;
    wire           mem_wrn = mem_o.wrn;

    logic [DW-1:0]     sram    [logic [MEM_AW-1:0]];   // SRAM array
    logic [DW-1:0]     ref_mem [logic [MEM_AW-1:0]];   // Expected contents
    logic [31:0]       lfsr_state = 32'h065a0830;
    int                n_errors   = 0;
    int                n_tests    = 0;
    logic [DW-1:0]     last_rdata;                     // Latest CPU access results
    logic [MEM_AW-1:0] last_cs_addr;
    logic              last_wr_seen;
    logic              cs_seen_any;                    // Sticky until a test clears it

    nora_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk6x = ~clk6x;

    // SRAM read data follows the strobes shortly after each edge
    always @(posedge clk6x)
    begin
        #DRV_DLY;
        if (!mem_o.csn && !mem_o.rdn && sram.exists(mem_o.addr))
            mem_rdata_i = sram[mem_o.addr];
        else
            mem_rdata_i = '0;
    end

    always @(posedge mem_wrn)                          // Store on the wrn release
        if (!rst_i && !mem_o.csn)
            sram[mem_o.addr] = mem_o.wdata;

    // Galois right shift with taps applied when bit 0 is set
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        n_errors++;
        $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
    endtask

    task automatic report_error(input string what);
        n_errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // Bank register, GPIO page and banked window are not plain SRAM
    function automatic logic is_mapped_io(input logic [CPU_AW-1:0] a);
        return (a == BANK_REG_ADDR) || (a[CPU_AW-1:4] == VIA_BASE[CPU_AW-1:4])
            || (a[CPU_AW-1:BANK_OFS_W] == BANK_WIN_BASE[CPU_AW-1:BANK_OFS_W]);
    endfunction

    // Per bit the output register where the pin is an output, else the pin
    function automatic logic [DW-1:0] expected_port_read(input logic [DW-1:0] out_reg,
                                                         input logic [DW-1:0] dir,
                                                         input logic [DW-1:0] pin);
        logic [DW-1:0] v;
        for (int b = 0; b < DW; b++)
            v[b] = dir[b] ? out_reg[b] : pin[b];
        return v;
    endfunction

    task automatic pick_direct_addr(output logic [CPU_AW-1:0] a);
        logic [31:0] r;
        do
        begin
            take_bits(CPU_AW, r);
            a = r[CPU_AW-1:0];
        end
        while (is_mapped_io(a));
    endtask

    // One CPU cycle from the phi2 fall to just before the next one
    task automatic cpu_access(input logic [CPU_AW-1:0] addr, input logic rwn,
                              input logic [DW-1:0] wdata);
        logic got_rd;
        got_rd       = 1'b0;
        last_wr_seen = 1'b0;
        last_cs_addr = '0;
        last_rdata   = '0;
        @(negedge cphi2_o);
        #DRV_DLY;
        cpu_bus_i.addr  = addr;
        cpu_bus_i.rwn   = rwn;
        cpu_bus_i.wdata = wdata;
        for (int k = 0; k < CYCLE_CLKS; k++)
        begin
            @(negedge clk6x);
            if (!mem_o.wrn && mem_o.csn)
                report_error("SRAM wrn low while csn high");
            if (k >= 3 && !mem_o.csn)                  // Previous csn gone by phase 3
            begin
                cs_seen_any  = 1'b1;
                last_cs_addr = mem_o.addr;
            end
            if (!mem_o.wrn)
                last_wr_seen = 1'b1;
            if (cpu_rdata_oe_o && !got_rd)             // First clock of read drive
            begin
                got_rd     = 1'b1;
                last_rdata = cpu_rdata_o;
            end
        end
        if (rwn && !got_rd)
            report_error("cpu_rdata_oe_o never rose during a read");
        if (!rwn && got_rd)
            report_error("cpu_rdata_oe_o rose during a write");
    endtask

    task automatic check_reset_state();
        logic [2:0] ph;
        if (mem_o.csn !== 1'b1)
            report_mismatch("mem_o.csn", 32'd1, 32'(mem_o.csn));
        if (mem_o.rdn !== 1'b1)
            report_mismatch("mem_o.rdn", 32'd1, 32'(mem_o.rdn));
        if (mem_o.wrn !== 1'b1)
            report_mismatch("mem_o.wrn", 32'd1, 32'(mem_o.wrn));
        if (cpu_rdata_oe_o !== 1'b0)
            report_mismatch("cpu_rdata_oe_o", 32'd0, 32'(cpu_rdata_oe_o));
        if (porta_oe_o !== '0)
            report_mismatch("porta_oe_o", 32'd0, 32'(porta_oe_o));
        if (portb_oe_o !== '0)
            report_mismatch("portb_oe_o", 32'd0, 32'(portb_oe_o));
        @(negedge cphi2_o);
        ph = 3'd0;
        repeat (2 * CYCLE_CLKS)                        // Two full CPU cycles
        begin
            @(negedge clk6x);
            if (cphi2_o !== (ph >= PH_PHI2_RISE))
                report_mismatch("cphi2_o", 32'(ph >= PH_PHI2_RISE), 32'(cphi2_o));
            ph = (ph == PHASES_PER_CYCLE - 3'd1) ? 3'd0 : ph + 3'd1;
        end
    endtask

    task automatic test_direct_sram();
        logic [CPU_AW-1:0] addrs [8];
        logic [31:0]       r;
        logic [MEM_AW-1:0] exp_addr;
        for (int i = 0; i < 8; i++)
        begin
            pick_direct_addr(addrs[i]);
            take_bits(DW, r);
            exp_addr          = {LOWMEM_PAGE, addrs[i]};   // Top page of SRAM
            ref_mem[exp_addr] = r[DW-1:0];
            cpu_access(addrs[i], 1'b0, r[DW-1:0]);
            if (last_cs_addr !== exp_addr)
                report_mismatch("mem_o.addr", 32'(exp_addr), 32'(last_cs_addr));
            if (!last_wr_seen)
                report_error("no wrn pulse on a direct SRAM write");
        end
        for (int i = 0; i < 8; i++)
        begin
            exp_addr = {LOWMEM_PAGE, addrs[i]};
            cpu_access(addrs[i], 1'b1, 8'h00);
            if (last_rdata !== ref_mem[exp_addr])
                report_mismatch("cpu_rdata_o", 32'(ref_mem[exp_addr]), 32'(last_rdata));
        end
    endtask

    task automatic test_bank_reg();
        logic [31:0]           r;
        logic [DW-1:0]         bank [2];
        logic [DW-1:0]         data [2];
        logic [BANK_OFS_W-1:0] ofs;
        logic [CPU_AW-1:0]     win_addr;
        cs_seen_any = 1'b0;
        cpu_access(BANK_REG_ADDR, 1'b0, 8'hFF);
        cpu_access(BANK_REG_ADDR, 1'b1, 8'h00);
        if (last_rdata !== 8'h7F)                      // 128 banks, top bit dropped
            report_mismatch("cpu_rdata_o", 32'h7F, 32'(last_rdata));
        if (cs_seen_any)
            report_error("bank register access lowered csn");
        for (int i = 0; i < 2; i++)
        begin
            take_bits(7, r);
            bank[i] = {1'b0, r[6:0]};
            take_bits(DW, r);
            data[i] = r[DW-1:0];
        end
        if (bank[1] == bank[0])
            bank[1] = bank[0] ^ 8'h01;                 // Two distinct banks
        if (data[1] == data[0])
            data[1] = ~data[0];
        take_bits(BANK_OFS_W, r);
        ofs      = r[BANK_OFS_W-1:0];
        win_addr = BANK_WIN_BASE + {3'b000, ofs};
        for (int i = 0; i < 2; i++)
        begin
            cpu_access(BANK_REG_ADDR, 1'b0, bank[i]);
            cpu_access(win_addr, 1'b0, data[i]);
            if (last_cs_addr !== {bank[i], ofs})
                report_mismatch("mem_o.addr", 32'({bank[i], ofs}), 32'(last_cs_addr));
        end
        for (int i = 0; i < 2; i++)                    // Same offset in separate banks
        begin
            cpu_access(BANK_REG_ADDR, 1'b0, bank[i]);
            cpu_access(win_addr, 1'b1, 8'h00);
            if (last_rdata !== data[i])
                report_mismatch("cpu_rdata_o", 32'(data[i]), 32'(last_rdata));
        end
    endtask

    task automatic test_gpio();
        logic [31:0]   r;
        logic [DW-1:0] pinb;
        logic [DW-1:0] ddrb;
        logic [DW-1:0] orb;
        logic [DW-1:0] exp_rd;
        take_bits(DW, r);
        pinb = r[DW-1:0];
        take_bits(DW, r);
        ddrb = r[DW-1:0];
        take_bits(DW, r);
        orb         = r[DW-1:0];
        cs_seen_any = 1'b0;
        @(posedge clk6x);
        #DRV_DLY;
        porta_i = 8'h3C;
        portb_i = pinb;
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_DDRA}, 1'b0, 8'h0F);
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_ORA}, 1'b0, 8'hA5);
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_ORA}, 1'b1, 8'h00);
        exp_rd = expected_port_read(8'hA5, 8'h0F, 8'h3C);  // Low nibble driven by ORA
        if (last_rdata !== exp_rd)
            report_mismatch("cpu_rdata_o", 32'(exp_rd), 32'(last_rdata));
        if (porta_oe_o !== 8'h0F)
            report_mismatch("porta_oe_o", 32'h0F, 32'(porta_oe_o));
        if (porta_o !== 8'hA5)
            report_mismatch("porta_o", 32'hA5, 32'(porta_o));
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_DDRB}, 1'b0, ddrb);
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_ORB}, 1'b0, orb);
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_ORB}, 1'b1, 8'h00);
        exp_rd = expected_port_read(orb, ddrb, pinb);
        if (last_rdata !== exp_rd)
            report_mismatch("cpu_rdata_o", 32'(exp_rd), 32'(last_rdata));
        cpu_access({VIA_BASE[CPU_AW-1:4], VIA_DDRB}, 1'b1, 8'h00);
        if (last_rdata !== ddrb)
            report_mismatch("cpu_rdata_o", 32'(ddrb), 32'(last_rdata));
        if (portb_o !== orb)
            report_mismatch("portb_o", 32'(orb), 32'(portb_o));
        if (portb_oe_o !== ddrb)
            report_mismatch("portb_oe_o", 32'(ddrb), 32'(portb_oe_o));
        if (cs_seen_any)
            report_error("GPIO access lowered csn");
    endtask

    task automatic test_run_stop();
        logic [CPU_AW-1:0] addr;
        logic [31:0]       r;
        logic              seen;
        pick_direct_addr(addr);
        take_bits(DW, r);
        ref_mem[{LOWMEM_PAGE, addr}] = r[DW-1:0];
        cpu_access(addr, 1'b0, r[DW-1:0]);
        @(negedge cphi2_o);
        #DRV_DLY;
        run_i = 1'b0;                                  // Current cycle still completes
        seen  = 1'b0;
        for (int k = 0; k < 2 * CYCLE_CLKS && !seen; k++)
        begin
            @(negedge clk6x);
            seen = stopped_o;
        end
        if (!seen)
            report_error("stopped_o did not rise after run_i went low");
        if (cphi2_o !== 1'b0)
            report_mismatch("cphi2_o", 32'd0, 32'(cphi2_o));
        @(negedge clk6x);                              // Last csn release
        repeat (30)
        begin
            @(negedge clk6x);
            if (cphi2_o !== 1'b0)
                report_mismatch("cphi2_o", 32'd0, 32'(cphi2_o));
            if (mem_o.csn !== 1'b1)
                report_mismatch("mem_o.csn", 32'd1, 32'(mem_o.csn));
        end
        @(posedge clk6x);
        #DRV_DLY;
        run_i = 1'b1;
        seen  = 1'b0;
        for (int k = 0; k < 2 * CYCLE_CLKS && !seen; k++)
        begin
            @(negedge clk6x);
            seen = cphi2_o;
        end
        if (!seen)
            report_error("cphi2_o did not resume after run_i went high");
        if (stopped_o !== 1'b0)
            report_mismatch("stopped_o", 32'd0, 32'(stopped_o));
        cpu_access(addr, 1'b1, 8'h00);
        if (last_rdata !== ref_mem[{LOWMEM_PAGE, addr}])
            report_mismatch("cpu_rdata_o", 32'(ref_mem[{LOWMEM_PAGE, addr}]), 32'(last_rdata));
    endtask

    initial
    begin
        rst_i           = 1'b1;
        run_i           = 1'b1;
        cpu_bus_i.addr  = 16'h0200;                    // Harmless SRAM read
        cpu_bus_i.rwn   = 1'b1;
        cpu_bus_i.wdata = '0;
        porta_i         = '0;
        portb_i         = '0;
        repeat (RST_CYCLES) @(posedge clk6x);
        #DRV_DLY;
        rst_i = 1'b0;
        check_reset_state();
        n_tests++;
        test_direct_sram();
        n_tests++;
        test_bank_reg();
        n_tests++;
        test_gpio();
        n_tests++;
        test_run_stop();
        n_tests++;
        $display("Tests run: %0d, errors: %0d", n_tests, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

/* build.f */
hdl/nora_pkg.sv
hdl/cpu_phaser.sv
hdl/bus_decoder.sv
hdl/gpio_via.sv
hdl/nora_top.sv
dv/tb_nora.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the bus core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_nora \
    -f build.f --Mdir "$BUILD_DIR" -o sim_nora
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_nora" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0
